// File: flist.f
+incdir+verif
hw/mips_id_pkg.sv
hw/op_decode.sv
hw/operand_bypass.sv
hw/id_ex_reg.sv
hw/id_stage.sv
verif/tb_id_stage.sv

// File: hw/id_ex_reg.sv
`timescale 1ns/1ps
`default_nettype none

module id_ex_reg
    import mips_id_pkg::*;
(
    input  wire                    clk,
    input  wire                    reset,
    input  wire                    in_valid,
    input  wire [ALU_OP_W-1:0]     alu_op,
    input  wire [ALU_SEL_W-1:0]    alu_sel,
    input  wire [DATA_W-1:0]       src1,
    input  wire [DATA_W-1:0]       src2,
    input  wire                    wr_en,
    input  wire [REG_ADDR_W-1:0]   wr_addr,
    output logic                   ex_valid,
    output logic [ALU_OP_W-1:0]    ex_alu_op,
    output logic [ALU_SEL_W-1:0]   ex_alu_sel,
    output logic [DATA_W-1:0]      ex_src1,
    output logic [DATA_W-1:0]      ex_src2,
    output logic                   ex_wr_en,
    output logic [REG_ADDR_W-1:0]  ex_wr_addr
);

    always_ff @(posedge clk) begin
        if (reset) begin
            ex_valid   <= 1'b0;
            ex_alu_op  <= ALU_NOP;
            ex_alu_sel <= SEL_NOP;
            ex_src1    <= '0;
            ex_src2    <= '0;
            ex_wr_en   <= 1'b0;
            ex_wr_addr <= '0;
        end else begin
            ex_valid   <= in_valid;
            ex_alu_op  <= alu_op;
            ex_alu_sel <= alu_sel;
            ex_src1    <= src1;
            ex_src2    <= src2;
            ex_wr_en   <= wr_en && in_valid;    // Bubbles never write back
            ex_wr_addr <= wr_addr;
        end
    end

    // A write reaching execute must belong to a real instruction
    a_wr_needs_valid: assert property (
        @(posedge clk) disable iff (reset)
        ex_wr_en |-> ex_valid
    ) else $error("id_ex_reg: write enable on an invalid slot");

endmodule

`default_nettype wire

// File: hw/id_stage.sv
`timescale 1ns/1ps
`default_nettype none

module id_stage
    import mips_id_pkg::*;
(
    input  wire                    clk,
    input  wire                    reset,
    input  wire                    in_valid,
    input  wire ins_t              ins,
    input  wire [DATA_W-1:0]       rf_data1,
    input  wire [DATA_W-1:0]       rf_data2,
    input  wire                    ex_fwd_en,
    input  wire [REG_ADDR_W-1:0]   ex_fwd_addr,
    input  wire [DATA_W-1:0]       ex_fwd_data,
    input  wire                    mem_fwd_en,
    input  wire [REG_ADDR_W-1:0]   mem_fwd_addr,
    input  wire [DATA_W-1:0]       mem_fwd_data,
    output logic [REG_ADDR_W-1:0]  addr1,
    output logic [REG_ADDR_W-1:0]  addr2,
    output logic                   ex_valid,
    output logic [ALU_OP_W-1:0]    ex_alu_op,
    output logic [ALU_SEL_W-1:0]   ex_alu_sel,
    output logic [DATA_W-1:0]      ex_src1,
    output logic [DATA_W-1:0]      ex_src2,
    output logic                   ex_wr_en,
    output logic [REG_ADDR_W-1:0]  ex_wr_addr
);

    logic                   rd1_en;
    logic                   rd2_en;
    logic [ALU_OP_W-1:0]    alu_op;
    logic [ALU_SEL_W-1:0]   alu_sel;
    logic                   wr_en;
    logic [REG_ADDR_W-1:0]  wr_addr;
    logic [DATA_W-1:0]      imm;
    logic [DATA_W-1:0]      src1;
    logic [DATA_W-1:0]      src2;

    op_decode op_decode_i (
        .ins     (ins),
        .rd1_en  (rd1_en),
        .rd2_en  (rd2_en),
        .addr1   (addr1),
        .addr2   (addr2),
        .alu_op  (alu_op),
        .alu_sel (alu_sel),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .imm     (imm)
    );

    operand_bypass bypass1_i (
        .rd_en        (rd1_en),
        .addr         (addr1),
        .rf_data      (rf_data1),
        .imm          (imm),
        .ex_fwd_en    (ex_fwd_en),
        .ex_fwd_addr  (ex_fwd_addr),
        .ex_fwd_data  (ex_fwd_data),
        .mem_fwd_en   (mem_fwd_en),
        .mem_fwd_addr (mem_fwd_addr),
        .mem_fwd_data (mem_fwd_data),
        .src          (src1)
    );

    operand_bypass bypass2_i (
        .rd_en        (rd2_en),
        .addr         (addr2),
        .rf_data      (rf_data2),
        .imm          (imm),
        .ex_fwd_en    (ex_fwd_en),
        .ex_fwd_addr  (ex_fwd_addr),
        .ex_fwd_data  (ex_fwd_data),
        .mem_fwd_en   (mem_fwd_en),
        .mem_fwd_addr (mem_fwd_addr),
        .mem_fwd_data (mem_fwd_data),
        .src          (src2)
    );

    id_ex_reg id_ex_reg_i (
        .clk        (clk),
        .reset      (reset),
        .in_valid   (in_valid),
        .alu_op     (alu_op),
        .alu_sel    (alu_sel),
        .src1       (src1),
        .src2       (src2),
        .wr_en      (wr_en),
        .wr_addr    (wr_addr),
        .ex_valid   (ex_valid),
        .ex_alu_op  (ex_alu_op),
        .ex_alu_sel (ex_alu_sel),
        .ex_src1    (ex_src1),
        .ex_src2    (ex_src2),
        .ex_wr_en   (ex_wr_en),
        .ex_wr_addr (ex_wr_addr)
    );

endmodule

`default_nettype wire

// File: hw/mips_id_pkg.sv
`default_nettype none

package mips_id_pkg;

    localparam int DATA_W     = 32;
    localparam int REG_ADDR_W = 5;
    localparam int OPCODE_W   = 6;
    localparam int FUNCT_W    = 6;
    localparam int SHAMT_W    = 5;
    localparam int IMM_W      = 16;
    localparam int ALU_OP_W   = 8;
    localparam int ALU_SEL_W  = 3;

    // Primary opcodes
    localparam logic [OPCODE_W-1:0] OPC_SPECIAL = 6'b000000;
    localparam logic [OPCODE_W-1:0] OPC_ADDI    = 6'b001000;
    localparam logic [OPCODE_W-1:0] OPC_ADDIU   = 6'b001001;
    localparam logic [OPCODE_W-1:0] OPC_SLTI    = 6'b001010;
    localparam logic [OPCODE_W-1:0] OPC_SLTIU   = 6'b001011;
    localparam logic [OPCODE_W-1:0] OPC_ANDI    = 6'b001100;
    localparam logic [OPCODE_W-1:0] OPC_ORI     = 6'b001101;
    localparam logic [OPCODE_W-1:0] OPC_XORI    = 6'b001110;
    localparam logic [OPCODE_W-1:0] OPC_LUI     = 6'b001111;

    // Function codes under OPC_SPECIAL
    localparam logic [FUNCT_W-1:0] FN_SLL  = 6'b000000;
    localparam logic [FUNCT_W-1:0] FN_SRL  = 6'b000010;
    localparam logic [FUNCT_W-1:0] FN_SRA  = 6'b000011;
    localparam logic [FUNCT_W-1:0] FN_SLLV = 6'b000100;
    localparam logic [FUNCT_W-1:0] FN_SRLV = 6'b000110;
    localparam logic [FUNCT_W-1:0] FN_SRAV = 6'b000111;
    localparam logic [FUNCT_W-1:0] FN_ADD  = 6'b100000;
    localparam logic [FUNCT_W-1:0] FN_ADDU = 6'b100001;
    localparam logic [FUNCT_W-1:0] FN_SUB  = 6'b100010;
    localparam logic [FUNCT_W-1:0] FN_SUBU = 6'b100011;
    localparam logic [FUNCT_W-1:0] FN_AND  = 6'b100100;
    localparam logic [FUNCT_W-1:0] FN_OR   = 6'b100101;
    localparam logic [FUNCT_W-1:0] FN_XOR  = 6'b100110;
    localparam logic [FUNCT_W-1:0] FN_NOR  = 6'b100111;
    localparam logic [FUNCT_W-1:0] FN_SLT  = 6'b101010;
    localparam logic [FUNCT_W-1:0] FN_SLTU = 6'b101011;

    // ALU operation codes as seen by the execute stage
    localparam logic [ALU_OP_W-1:0] ALU_NOP   = 8'b00000000;
    localparam logic [ALU_OP_W-1:0] ALU_AND   = 8'b00100100;
    localparam logic [ALU_OP_W-1:0] ALU_OR    = 8'b00100101;
    localparam logic [ALU_OP_W-1:0] ALU_XOR   = 8'b00100110;
    localparam logic [ALU_OP_W-1:0] ALU_NOR   = 8'b00100111;
    localparam logic [ALU_OP_W-1:0] ALU_SLL   = 8'b01111100;
    localparam logic [ALU_OP_W-1:0] ALU_SRL   = 8'b00000010;
    localparam logic [ALU_OP_W-1:0] ALU_SRA   = 8'b00000011;
    localparam logic [ALU_OP_W-1:0] ALU_ADD   = 8'b00100000;
    localparam logic [ALU_OP_W-1:0] ALU_ADDU  = 8'b00100001;
    localparam logic [ALU_OP_W-1:0] ALU_SUB   = 8'b00100010;
    localparam logic [ALU_OP_W-1:0] ALU_SUBU  = 8'b00100011;
    localparam logic [ALU_OP_W-1:0] ALU_SLT   = 8'b00101010;
    localparam logic [ALU_OP_W-1:0] ALU_SLTU  = 8'b00101011;
    localparam logic [ALU_OP_W-1:0] ALU_ADDI  = 8'b01010101;
    localparam logic [ALU_OP_W-1:0] ALU_ADDIU = 8'b01010110;

    // Execute unit select
    localparam logic [ALU_SEL_W-1:0] SEL_NOP   = 3'b000;
    localparam logic [ALU_SEL_W-1:0] SEL_LOGIC = 3'b001;
    localparam logic [ALU_SEL_W-1:0] SEL_SHIFT = 3'b010;
    localparam logic [ALU_SEL_W-1:0] SEL_ARITH = 3'b100;

    typedef struct packed {
        logic [OPCODE_W-1:0]   opcode;
        logic [REG_ADDR_W-1:0] rs;
        logic [REG_ADDR_W-1:0] rt;
        logic [REG_ADDR_W-1:0] rd;
        logic [SHAMT_W-1:0]    shamt;
        logic [FUNCT_W-1:0]    funct;
    } r_ins_t;

    typedef struct packed {
        logic [OPCODE_W-1:0]   opcode;
        logic [REG_ADDR_W-1:0] rs;
        logic [REG_ADDR_W-1:0] rt;
        logic [IMM_W-1:0]      imm;
    } i_ins_t;

    typedef union packed {
        r_ins_t r;
        i_ins_t i;
    } ins_t;

endpackage

`default_nettype wire

// File: hw/op_decode.sv
`timescale 1ns/1ps
`default_nettype none

module op_decode
    import mips_id_pkg::*;
(
    input  wire ins_t                  ins,
    output logic                       rd1_en,
    output logic                       rd2_en,
    output logic [REG_ADDR_W-1:0]      addr1,
    output logic [REG_ADDR_W-1:0]      addr2,
    output logic [ALU_OP_W-1:0]        alu_op,
    output logic [ALU_SEL_W-1:0]       alu_sel,
    output logic                       wr_en,
    output logic [REG_ADDR_W-1:0]      wr_addr,
    output logic [DATA_W-1:0]          imm
);

    logic [DATA_W-1:0] imm_zext;
    logic [DATA_W-1:0] imm_sext;
    logic [DATA_W-1:0] imm_upper;
    logic [DATA_W-1:0] imm_shamt;

    assign imm_zext  = {{(DATA_W-IMM_W){1'b0}}, ins.i.imm};
    assign imm_sext  = {{(DATA_W-IMM_W){ins.i.imm[IMM_W-1]}}, ins.i.imm};
    assign imm_upper = {ins.i.imm, {(DATA_W-IMM_W){1'b0}}};
    assign imm_shamt = {{(DATA_W-SHAMT_W){1'b0}}, ins.r.shamt};

    // Source registers always come from rs and rt
    assign addr1 = ins.i.rs;
    assign addr2 = ins.i.rt;

    always_comb begin
        alu_op  = ALU_NOP;                      // Bubble unless matched below
        alu_sel = SEL_NOP;
        rd1_en  = 1'b0;
        rd2_en  = 1'b0;
        wr_en   = 1'b0;
        wr_addr = ins.r.rd;
        imm     = '0;

        if (ins.i.opcode == OPC_SPECIAL) begin
            case (ins.r.funct)
                FN_AND:  alu_op = ALU_AND;
                FN_OR:   alu_op = ALU_OR;
                FN_XOR:  alu_op = ALU_XOR;
                FN_NOR:  alu_op = ALU_NOR;
                FN_SLL:  alu_op = ALU_SLL;
                FN_SLLV: alu_op = ALU_SLL;
                FN_SRL:  alu_op = ALU_SRL;
                FN_SRLV: alu_op = ALU_SRL;
                FN_SRA:  alu_op = ALU_SRA;
                FN_SRAV: alu_op = ALU_SRA;
                FN_ADD:  alu_op = ALU_ADD;
                FN_ADDU: alu_op = ALU_ADDU;
                FN_SUB:  alu_op = ALU_SUB;
                FN_SUBU: alu_op = ALU_SUBU;
                FN_SLT:  alu_op = ALU_SLT;
                FN_SLTU: alu_op = ALU_SLTU;
                default: alu_op = ALU_NOP;
            endcase

            case (ins.r.funct)
                FN_AND, FN_OR, FN_XOR, FN_NOR:
                    alu_sel = SEL_LOGIC;
                FN_SLL, FN_SRL, FN_SRA, FN_SLLV, FN_SRLV, FN_SRAV:
                    alu_sel = SEL_SHIFT;
                FN_ADD, FN_ADDU, FN_SUB, FN_SUBU, FN_SLT, FN_SLTU:
                    alu_sel = SEL_ARITH;
                default:
                    alu_sel = SEL_NOP;
            endcase

            if (alu_sel != SEL_NOP) begin
                rd1_en = 1'b1;
                rd2_en = 1'b1;
                wr_en  = 1'b1;
            end

            // Constant shifts take shamt in place of rs
            if (ins.r.funct == FN_SLL || ins.r.funct == FN_SRL || ins.r.funct == FN_SRA) begin
                rd1_en = 1'b0;
                imm    = imm_shamt;
            end
        end else begin
            case (ins.i.opcode)
                OPC_ANDI: begin
                    alu_op  = ALU_AND;
                    alu_sel = SEL_LOGIC;
                    imm     = imm_zext;
                end
                OPC_ORI: begin
                    alu_op  = ALU_OR;
                    alu_sel = SEL_LOGIC;
                    imm     = imm_zext;
                end
                OPC_XORI: begin
                    alu_op  = ALU_XOR;
                    alu_sel = SEL_LOGIC;
                    imm     = imm_zext;
                end
                OPC_LUI: begin
                    alu_op  = ALU_OR;           // Upper half ORed with rs
                    alu_sel = SEL_LOGIC;
                    imm     = imm_upper;
                end
                OPC_ADDI, OPC_ADDIU, OPC_SLTI, OPC_SLTIU: begin
                    alu_sel = SEL_ARITH;
                    imm     = imm_sext;
                end
                default: begin
                end
            endcase

            case (ins.i.opcode)
                OPC_ADDI:  alu_op = ALU_ADDI;
                OPC_ADDIU: alu_op = ALU_ADDIU;
                OPC_SLTI:  alu_op = ALU_SLT;
                OPC_SLTIU: alu_op = ALU_SLTU;
                default: begin
                end
            endcase

            if (alu_sel != SEL_NOP) begin
                rd1_en  = 1'b1;
                wr_en   = 1'b1;
                wr_addr = ins.i.rt;             // I-type writes rt
            end
        end

        assert (!wr_en || rd1_en || rd2_en)
            else $error("op_decode: register write with no source read");
    end

endmodule

`default_nettype wire

// File: hw/operand_bypass.sv
`timescale 1ns/1ps
`default_nettype none

module operand_bypass
    import mips_id_pkg::*;
(
    input  wire                    rd_en,
    input  wire [REG_ADDR_W-1:0]   addr,
    input  wire [DATA_W-1:0]       rf_data,
    input  wire [DATA_W-1:0]       imm,
    input  wire                    ex_fwd_en,
    input  wire [REG_ADDR_W-1:0]   ex_fwd_addr,
    input  wire [DATA_W-1:0]       ex_fwd_data,
    input  wire                    mem_fwd_en,
    input  wire [REG_ADDR_W-1:0]   mem_fwd_addr,
    input  wire [DATA_W-1:0]       mem_fwd_data,
    output logic [DATA_W-1:0]      src
);

    logic ex_hit;
    logic mem_hit;

    assign ex_hit  = ex_fwd_en && (ex_fwd_addr == addr);
    assign mem_hit = mem_fwd_en && (mem_fwd_addr == addr);

    always_comb begin
        if (!rd_en) begin
            src = imm;
        end else if (ex_hit) begin
            src = ex_fwd_data;                  // Youngest result wins
        end else if (mem_hit) begin
            src = mem_fwd_data;
        end else begin
            src = rf_data;
        end

        assert (rd_en || src == imm)
            else $error("operand_bypass: immediate not selected with read disabled");
    end

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# Build and run the ID stage testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f flist.f --top-module tb_id_stage -o sim_id_stage
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_id_stage > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qF "*** TEST PASSED ***" sim.log; then
    exit 0
fi
echo "Pass message not found in sim.log"
exit 1

// File: verif/tb_expect.svh
`ifndef TB_EXPECT_SVH
`define TB_EXPECT_SVH

function automatic ins_t encode_r(input logic [REG_ADDR_W-1:0] rs,
                                  input logic [REG_ADDR_W-1:0] rt,
                                  input logic [REG_ADDR_W-1:0] rd,
                                  input logic [SHAMT_W-1:0] shamt,
                                  input logic [FUNCT_W-1:0] funct);
    ins_t word;
    word.r.opcode = OPC_SPECIAL;
    word.r.rs     = rs;
    word.r.rt     = rt;
    word.r.rd     = rd;
    word.r.shamt  = shamt;
    word.r.funct  = funct;
    return word;
endfunction

function automatic ins_t encode_i(input logic [OPCODE_W-1:0] opcode,
                                  input logic [REG_ADDR_W-1:0] rs,
                                  input logic [REG_ADDR_W-1:0] rt,
                                  input logic [IMM_W-1:0] imm16);
    ins_t word;
    word.i.opcode = opcode;
    word.i.rs     = rs;
    word.i.rt     = rt;
    word.i.imm    = imm16;
    return word;
endfunction

// Logical immediates are unsigned, LUI fills the upper half
function automatic logic [DATA_W-1:0] ext_imm(input logic [OPCODE_W-1:0] opcode,
                                              input logic [IMM_W-1:0] imm16);
    case (opcode)
        OPC_ANDI, OPC_ORI, OPC_XORI: return {16'h0000, imm16};
        OPC_LUI:                     return {imm16, 16'h0000};
        default:                     return {{16{imm16[15]}}, imm16};
    endcase
endfunction

function automatic logic [DATA_W-1:0] select_operand(
    input logic rd_en, input logic [REG_ADDR_W-1:0] addr,
    input logic [DATA_W-1:0] rf, input logic [DATA_W-1:0] imm,
    input logic ex_en, input logic [REG_ADDR_W-1:0] ex_addr, input logic [DATA_W-1:0] ex_data,
    input logic mem_en, input logic [REG_ADDR_W-1:0] mem_addr,
    input logic [DATA_W-1:0] mem_data);
    if (!rd_en) return imm;
    if (ex_en && ex_addr == addr) return ex_data;    // Execute result is newer
    if (mem_en && mem_addr == addr) return mem_data;
    return rf;
endfunction

`endif

// File: verif/tb_id_stage.sv
`timescale 1ns/1ps
`default_nettype none

module tb_id_stage
    import mips_id_pkg::*;
();

    localparam int  EDGE_LIMIT = 4;
    localparam time RUN_LIMIT  = 100us;

    logic                  clk;
    logic                  reset;
    logic                  in_valid;
    ins_t                  ins;
    logic [DATA_W-1:0]     rf_data1;
    logic [DATA_W-1:0]     rf_data2;
    logic                  ex_fwd_en;
    logic [REG_ADDR_W-1:0] ex_fwd_addr;
    logic [DATA_W-1:0]     ex_fwd_data;
    logic                  mem_fwd_en;
    logic [REG_ADDR_W-1:0] mem_fwd_addr;
    logic [DATA_W-1:0]     mem_fwd_data;
    logic [REG_ADDR_W-1:0] addr1;
    logic [REG_ADDR_W-1:0] addr2;
    logic                  ex_valid;
    logic [ALU_OP_W-1:0]   ex_alu_op;
    logic [ALU_SEL_W-1:0]  ex_alu_sel;
    logic [DATA_W-1:0]     ex_src1;
    logic [DATA_W-1:0]     ex_src2;
    logic                  ex_wr_en;
    logic [REG_ADDR_W-1:0] ex_wr_addr;

    `include "tb_expect.svh"

    id_stage id_stage_i (
        .clk          (clk),
        .reset        (reset),
        .in_valid     (in_valid),
        .ins          (ins),
        .rf_data1     (rf_data1),
        .rf_data2     (rf_data2),
        .ex_fwd_en    (ex_fwd_en),
        .ex_fwd_addr  (ex_fwd_addr),
        .ex_fwd_data  (ex_fwd_data),
        .mem_fwd_en   (mem_fwd_en),
        .mem_fwd_addr (mem_fwd_addr),
        .mem_fwd_data (mem_fwd_data),
        .addr1        (addr1),
        .addr2        (addr2),
        .ex_valid     (ex_valid),
        .ex_alu_op    (ex_alu_op),
        .ex_alu_sel   (ex_alu_sel),
        .ex_src1      (ex_src1),
        .ex_src2      (ex_src2),
        .ex_wr_en     (ex_wr_en),
        .ex_wr_addr   (ex_wr_addr)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        #RUN_LIMIT;
        $display("Simulation ran past its time limit");
        $display("*** TEST FAILED ***");
        $fatal(1, "run time limit reached");
    end

    task automatic wait_edge(input logic level);
        int edges;
        edges = 0;
        do begin
            if (edges == EDGE_LIMIT) begin
                $display("Clock edge to %b not seen after %0d transitions", level, EDGE_LIMIT);
                $display("*** TEST FAILED ***");
                $fatal(1, "clock wait timed out");
            end
            @(clk);
            edges++;
        end while (clk !== level);
    endtask

    task automatic compare(input string name, input string what,
                           input logic [DATA_W-1:0] expected, input logic [DATA_W-1:0] actual);
        if (actual !== expected) begin
            $display("Error: %s %s expected %h actual %h", name, what, expected, actual);
            $display("*** TEST FAILED ***");
            $fatal(1, "mismatch in %s", name);
        end
    endtask

    // Drive at the falling edge, sample at the next falling edge
    task automatic apply_and_check(input string name, input ins_t word,
                                   input logic [ALU_OP_W-1:0] exp_op,
                                   input logic [ALU_SEL_W-1:0] exp_sel,
                                   input logic rd1_en, input logic rd2_en,
                                   input logic [DATA_W-1:0] exp_imm,
                                   input logic exp_wr, input logic [REG_ADDR_W-1:0] exp_wr_addr);
        logic [DATA_W-1:0] exp_src1;
        logic [DATA_W-1:0] exp_src2;
        exp_src1 = select_operand(rd1_en, word.r.rs, rf_data1, exp_imm, ex_fwd_en, ex_fwd_addr,
                                  ex_fwd_data, mem_fwd_en, mem_fwd_addr, mem_fwd_data);
        exp_src2 = select_operand(rd2_en, word.r.rt, rf_data2, exp_imm, ex_fwd_en, ex_fwd_addr,
                                  ex_fwd_data, mem_fwd_en, mem_fwd_addr, mem_fwd_data);
        ins      = word;
        in_valid = 1'b1;
        wait_edge(1'b1);
        wait_edge(1'b0);
        compare(name, "addr1", DATA_W'(word.r.rs), DATA_W'(addr1));
        compare(name, "addr2", DATA_W'(word.r.rt), DATA_W'(addr2));
        compare(name, "ex_valid", DATA_W'(1'b1), DATA_W'(ex_valid));
        compare(name, "ex_alu_op", DATA_W'(exp_op), DATA_W'(ex_alu_op));
        compare(name, "ex_alu_sel", DATA_W'(exp_sel), DATA_W'(ex_alu_sel));
        compare(name, "ex_src1", exp_src1, ex_src1);
        compare(name, "ex_src2", exp_src2, ex_src2);
        compare(name, "ex_wr_en", DATA_W'(exp_wr), DATA_W'(ex_wr_en));
        if (exp_wr) begin
            compare(name, "ex_wr_addr", DATA_W'(exp_wr_addr), DATA_W'(ex_wr_addr));
        end
    endtask

    task automatic test_idle();
        compare("idle", "ex_valid", '0, DATA_W'(ex_valid));
        compare("idle", "ex_wr_en", '0, DATA_W'(ex_wr_en));
        compare("idle", "ex_src1", '0, ex_src1);
        compare("idle", "ex_src2", '0, ex_src2);
        compare("idle", "ex_alu_op", '0, DATA_W'(ex_alu_op));
        compare("idle", "ex_alu_sel", '0, DATA_W'(ex_alu_sel));
        compare("idle", "ex_wr_addr", '0, DATA_W'(ex_wr_addr));
        ins      = encode_r(5'd1, 5'd2, 5'd3, 5'd0, FN_ADD);
        in_valid = 1'b0;                                   // Real opcode, but a bubble
        wait_edge(1'b1);
        wait_edge(1'b0);
        compare("bubble", "ex_valid", '0, DATA_W'(ex_valid));
        compare("bubble", "ex_wr_en", '0, DATA_W'(ex_wr_en));
    endtask

    task automatic test_rtype(input string name, input logic [FUNCT_W-1:0] funct,
                              input logic [ALU_OP_W-1:0] exp_op,
                              input logic [ALU_SEL_W-1:0] exp_sel);
        logic [REG_ADDR_W-1:0] rd;
        rd       = 5'($urandom);
        rf_data1 = $urandom;
        rf_data2 = $urandom;
        apply_and_check(name, encode_r(5'($urandom), 5'($urandom), rd, 5'd0, funct),
                        exp_op, exp_sel, 1'b1, 1'b1, '0, 1'b1, rd);
    endtask

    task automatic test_shift_const(input string name, input logic [FUNCT_W-1:0] funct,
                                    input logic [ALU_OP_W-1:0] exp_op);
        logic [REG_ADDR_W-1:0] rd;
        logic [SHAMT_W-1:0]    shamt;
        rd       = 5'($urandom);
        shamt    = 5'($urandom);
        rf_data1 = $urandom;
        rf_data2 = $urandom;
        apply_and_check(name, encode_r(5'($urandom), 5'($urandom), rd, shamt, funct),
                        exp_op, SEL_SHIFT, 1'b0, 1'b1, {27'd0, shamt}, 1'b1, rd);
    endtask

    task automatic test_itype(input string name, input logic [OPCODE_W-1:0] opcode,
                              input logic [ALU_OP_W-1:0] exp_op,
                              input logic [ALU_SEL_W-1:0] exp_sel, input logic sign_bit);
        logic [REG_ADDR_W-1:0] rt;
        logic [IMM_W-1:0]      imm16;
        rt        = 5'($urandom);
        imm16     = 16'($urandom);
        imm16[15] = sign_bit;
        rf_data1  = $urandom;
        rf_data2  = $urandom;
        apply_and_check(name, encode_i(opcode, 5'($urandom), rt, imm16), exp_op, exp_sel,
                        1'b1, 1'b0, ext_imm(opcode, imm16), 1'b1, rt);
    endtask

    task automatic test_bypass();
        rf_data1     = $urandom;
        rf_data2     = $urandom;
        ex_fwd_en    = 1'b1;
        ex_fwd_data  = $urandom;
        mem_fwd_en   = 1'b1;
        mem_fwd_data = $urandom;
        ex_fwd_addr  = 5'd3;                               // Both stages hold r3
        mem_fwd_addr = 5'd3;
        apply_and_check("bypass_ex_wins", encode_r(5'd3, 5'd7, 5'd9, 5'd0, FN_ADD),
                        ALU_ADD, SEL_ARITH, 1'b1, 1'b1, '0, 1'b1, 5'd9);
        ex_fwd_addr  = 5'd12;
        mem_fwd_addr = 5'd7;
        apply_and_check("bypass_mem_only", encode_r(5'd3, 5'd7, 5'd9, 5'd0, FN_SUB),
                        ALU_SUB, SEL_ARITH, 1'b1, 1'b1, '0, 1'b1, 5'd9);
        apply_and_check("bypass_imm_kept", encode_i(OPC_ORI, 5'd7, 5'd12, 16'h8a5c),
                        ALU_OR, SEL_LOGIC, 1'b1, 1'b0, 32'h0000_8a5c, 1'b1, 5'd12);
        ex_fwd_en  = 1'b0;
        mem_fwd_en = 1'b0;
    endtask

    task automatic test_unsupported();
        apply_and_check("mult", encode_r(5'd4, 5'd5, 5'd6, 5'd0, 6'b011000),
                        ALU_NOP, SEL_NOP, 1'b0, 1'b0, '0, 1'b0, '0);
        apply_and_check("load_word", encode_i(6'b100011, 5'd4, 5'd5, 16'h0040),
                        ALU_NOP, SEL_NOP, 1'b0, 1'b0, '0, 1'b0, '0);
    endtask

    initial begin
        void'($urandom(32'h4f12));
        reset        = 1'b1;
        in_valid     = 1'b0;
        ins          = '0;
        rf_data1     = '0;
        rf_data2     = '0;
        ex_fwd_en    = 1'b0;
        ex_fwd_addr  = '0;
        ex_fwd_data  = '0;
        mem_fwd_en   = 1'b0;
        mem_fwd_addr = '0;
        mem_fwd_data = '0;
        wait_edge(1'b1);
        wait_edge(1'b1);
        wait_edge(1'b0);
        reset = 1'b0;

        test_idle();
        test_rtype("and", FN_AND, ALU_AND, SEL_LOGIC);
        test_rtype("or", FN_OR, ALU_OR, SEL_LOGIC);
        test_rtype("xor", FN_XOR, ALU_XOR, SEL_LOGIC);
        test_rtype("nor", FN_NOR, ALU_NOR, SEL_LOGIC);
        test_rtype("add", FN_ADD, ALU_ADD, SEL_ARITH);
        test_rtype("addu", FN_ADDU, ALU_ADDU, SEL_ARITH);
        test_rtype("sub", FN_SUB, ALU_SUB, SEL_ARITH);
        test_rtype("subu", FN_SUBU, ALU_SUBU, SEL_ARITH);
        test_rtype("slt", FN_SLT, ALU_SLT, SEL_ARITH);
        test_rtype("sltu", FN_SLTU, ALU_SLTU, SEL_ARITH);
        for (int s = 0; s < 2; s++) begin
            test_itype("andi", OPC_ANDI, ALU_AND, SEL_LOGIC, s[0]);
            test_itype("ori", OPC_ORI, ALU_OR, SEL_LOGIC, s[0]);
            test_itype("xori", OPC_XORI, ALU_XOR, SEL_LOGIC, s[0]);
            test_itype("lui", OPC_LUI, ALU_OR, SEL_LOGIC, s[0]);
            test_itype("addi", OPC_ADDI, ALU_ADDI, SEL_ARITH, s[0]);
            test_itype("addiu", OPC_ADDIU, ALU_ADDIU, SEL_ARITH, s[0]);
            test_itype("slti", OPC_SLTI, ALU_SLT, SEL_ARITH, s[0]);
            test_itype("sltiu", OPC_SLTIU, ALU_SLTU, SEL_ARITH, s[0]);
        end
        test_shift_const("sll", FN_SLL, ALU_SLL);
        test_shift_const("srl", FN_SRL, ALU_SRL);
        test_shift_const("sra", FN_SRA, ALU_SRA);
        test_rtype("sllv", FN_SLLV, ALU_SLL, SEL_SHIFT);
        test_rtype("srlv", FN_SRLV, ALU_SRL, SEL_SHIFT);
        test_rtype("srav", FN_SRAV, ALU_SRA, SEL_SHIFT);
        test_bypass();
        test_unsupported();

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire
